//--- sim.f
common/sdram_pkg.sv
sdram_model/sdram_row_table.sv
sdram_model/sdram_burst_seq.sv
sdram_model/sdram_array.sv
sdram_model/sdram_model.sv
verilog/sdram_host_ctrl.sv
verilog/sdram_subsys.sv
sim/sdram_subsys_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module sdram_subsys_tb -o vsim \
    && ./obj_dir/vsim > sim.log 2>&1 || echo "build or run error" >> sim.log
cat sim.log
grep -q "^All checks passed$" sim.log && exit 0 || exit 1

//--- sim/sdram_subsys_tb.sv
// testbench for the SDRAM subsystem
// clock, reset, LCG stimulus, reference memory, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_tb;

    localparam int PERIOD     = 8;
    localparam int N_RANDOM   = 40;
    localparam int N_REQ      = 19 + N_RANDOM;  // directed plus random requests
    localparam int REQ_CYCLES = 20;             // bound per request
    localparam int TIMEOUT_NS = (N_REQ + 2) * REQ_CYCLES * PERIOD;
    localparam int HA_W       = $bits(sdram_pkg::host_addr_t);
    localparam int N_WORDS    = 2**HA_W;
    localparam int DW         = sdram_pkg::DATA_W;

    logic                  clk;
    logic                  cke;
    logic                  req;
    logic                  we;
    sdram_pkg::host_addr_t addr;
    sdram_pkg::burst_t     wdata;
    wire                   ack;
    wire sdram_pkg::burst_t rdata;

    sdram_pkg::word_t      ref_mem [N_WORDS];
    logic                  ref_valid [N_WORDS];
    sdram_pkg::host_addr_t wr_addrs [$];
    logic [31:0]           seed;
    int                    n_checks;
    int                    n_errors;
    logic                  ack_q = 1'b0;
    logic                  req_q = 1'b0;

    sdram_subsys sdram_subsys_i (
        .clk     (clk),
        .cke     (cke),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .ack_o   (ack),
        .rdata_o (rdata)
    );

    always #(PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output logic [31:0] r);
        seed = lcg_next(seed);
        r    = seed;
    endtask

    function automatic sdram_pkg::host_addr_t make_addr(input int bank, input int row,
                                                        input int col);
        return {bank[1:0], row[3:0], col[4:0]};
    endfunction

    // word index of beat k with the column wrapped inside the row
    function automatic int word_index(input sdram_pkg::host_addr_t a, input int k);
        logic [sdram_pkg::COL_W-1:0] col;
        col = a[sdram_pkg::COL_W-1:0] + k[sdram_pkg::COL_W-1:0];
        return int'({a[HA_W-1:sdram_pkg::COL_W], col});
    endfunction

    function automatic sdram_pkg::burst_t expected_burst(input sdram_pkg::host_addr_t a);
        sdram_pkg::burst_t b;
        b = '0;
        for (int k = 0; k < sdram_pkg::BURST_LEN; k++) begin
            b[k*DW +: DW] = ref_mem[word_index(a, k)];
        end
        return b;
    endfunction

    // words never written are left out of the compare
    function automatic sdram_pkg::burst_t valid_mask(input sdram_pkg::host_addr_t a);
        sdram_pkg::burst_t m;
        m = '0;
        for (int k = 0; k < sdram_pkg::BURST_LEN; k++) begin
            m[k*DW +: DW] = ref_valid[word_index(a, k)] ? '1 : '0;
        end
        return m;
    endfunction

    task automatic compare(input string name, input sdram_pkg::burst_t got,
                           input sdram_pkg::burst_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one four-phase request returning the read burst
    task automatic run_burst(input logic wr, input sdram_pkg::host_addr_t a,
                             input sdram_pkg::burst_t d, output sdram_pkg::burst_t q);
        @(negedge clk);
        req   = 1'b1;
        we    = wr;
        addr  = a;
        wdata = d;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        q   = rdata;
        req = 1'b0;
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic write_burst(input sdram_pkg::host_addr_t a, input sdram_pkg::burst_t d);
        sdram_pkg::burst_t q;
        run_burst(1'b1, a, d, q);
        for (int k = 0; k < sdram_pkg::BURST_LEN; k++) begin
            ref_mem[word_index(a, k)]   = d[k*DW +: DW];
            ref_valid[word_index(a, k)] = 1'b1;
        end
        wr_addrs.push_back(a);
    endtask

    task automatic read_burst(input sdram_pkg::host_addr_t a);
        sdram_pkg::burst_t q;
        sdram_pkg::burst_t m;
        run_burst(1'b0, a, '0, q);
        m = valid_mask(a);
        compare("rdata_o", q & m, expected_burst(a) & m);
    endtask

    // ack may only rise with req high and only fall after req drops
    always @(posedge clk) begin
        if (cke) begin
            if (ack && !ack_q && !req_q) begin
                n_errors++;
                $display("ERROR at %0t ns: ack_o rose without a pending req_i", $time);
            end
            if (!ack && ack_q && req_q) begin
                n_errors++;
                $display("ERROR at %0t ns: ack_o fell while req_i was still high", $time);
            end
        end
        ack_q <= ack;
        req_q <= req;
    end

    initial begin
        sdram_pkg::burst_t     d;
        sdram_pkg::host_addr_t a;
        logic [31:0]           r;
        int                    idx;
        clk      = 1'b0;
        cke      = 1'b0;
        req      = 1'b0;
        we       = 1'b0;
        addr     = '0;
        wdata    = '0;
        seed     = 32'h2c84;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < N_WORDS; i++) begin
            ref_mem[i]   = '0;
            ref_valid[i] = 1'b0;
        end
        repeat (5) @(negedge clk);
        cke = 1'b1;

        write_burst(make_addr(1, 7, 4), 64'h1111_2222_3333_4444);
        read_burst(make_addr(1, 7, 4));

        write_burst(make_addr(0, 5, 0), 64'h5a5a_a5a5_0f0f_f0f0);
        write_burst(make_addr(0, 4, 30), 64'hdead_beef_cafe_f00d); // wraps to col 0 and 1
        read_burst(make_addr(0, 4, 30));
        read_burst(make_addr(0, 4, 0));
        read_burst(make_addr(0, 5, 0));

        for (int b = 0; b < 4; b++) begin
            write_burst(make_addr(b, 2, 12), {4{16'h0b00 + 16'(b)}});
        end
        for (int b = 0; b < 4; b++) begin
            read_burst(make_addr(b, 2, 12));
        end

        write_burst(make_addr(3, 3, 8), 64'h0303_0303_0808_0808);
        write_burst(make_addr(3, 9, 8), 64'h0909_0909_0808_0808);
        read_burst(make_addr(3, 3, 8));
        read_burst(make_addr(3, 9, 8));

        for (int i = 0; i < N_RANDOM; i++) begin
            next_random(r);
            if (r[31] || wr_addrs.size() == 0) begin
                a = r[HA_W+15:16];
                for (int k = 0; k < sdram_pkg::BURST_LEN; k++) begin
                    next_random(r);
                    d[k*DW +: DW] = r[31:16];
                end
                write_burst(a, d);
            end else begin
                idx = int'(r[23:16]) % wr_addrs.size(); // read back an earlier write
                read_burst(wr_addrs[idx]);
            end
        end

        repeat (4) @(negedge clk);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: a request was not acknowledged in time, the run is stopped");
        $display("%0d checks, %0d errors", n_checks, n_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/sdram_subsys.sv
// top level joining the host controller and the SDRAM model
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys (
    input  wire                        clk,
    input  wire                        cke,
    input  wire                        req_i,
    input  wire                        we_i,
    input  wire sdram_pkg::host_addr_t addr_i,
    input  wire sdram_pkg::burst_t     wdata_i,
    output wire                        ack_o,
    output wire sdram_pkg::burst_t     rdata_o
);

    logic             sd_cs;
    logic             sd_ras;
    logic             sd_cas;
    logic             sd_we;
    sdram_pkg::addr_t sd_a;
    sdram_pkg::bank_t sd_ba;
    sdram_pkg::word_t sd_dq_w;
    sdram_pkg::word_t sd_dq_r;
    logic             sd_dq_oe;

    sdram_host_ctrl sdram_host_ctrl_i (
        .clk        (clk),
        .cke        (cke),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o),
        .sd_cs_o    (sd_cs),
        .sd_ras_o   (sd_ras),
        .sd_cas_o   (sd_cas),
        .sd_we_o    (sd_we),
        .sd_a_o     (sd_a),
        .sd_ba_o    (sd_ba),
        .sd_dq_o    (sd_dq_w),
        .sd_dq_i    (sd_dq_r),
        .sd_dq_oe_i (sd_dq_oe)
    );

    sdram_model sdram_model_i (
        .clk     (clk),
        .cke     (cke),
        .cs_i    (sd_cs),
        .ras_i   (sd_ras),
        .cas_i   (sd_cas),
        .we_i    (sd_we),
        .a_i     (sd_a),
        .ba_i    (sd_ba),
        .dq_i    (sd_dq_w),
        .dq_o    (sd_dq_r),
        .dq_oe_o (sd_dq_oe)
    );

endmodule

`default_nettype wire

//--- verilog/sdram_host_ctrl.sv
// four-phase req/ack host port
// SDRAM command sequencer issuing one mode load, then activate and burst per request
`timescale 1ns/1ps
`default_nettype none

module sdram_host_ctrl (
    input  wire                        clk,
    input  wire                        cke,
    input  wire                        req_i,
    input  wire                        we_i,
    input  wire sdram_pkg::host_addr_t addr_i,
    input  wire sdram_pkg::burst_t     wdata_i,
    output logic                       ack_o,
    output sdram_pkg::burst_t          rdata_o,
    output logic                       sd_cs_o,
    output logic                       sd_ras_o,
    output logic                       sd_cas_o,
    output logic                       sd_we_o,
    output sdram_pkg::addr_t           sd_a_o,
    output sdram_pkg::bank_t           sd_ba_o,
    output sdram_pkg::word_t           sd_dq_o,
    input  wire sdram_pkg::word_t      sd_dq_i,
    input  wire                        sd_dq_oe_i
);

    typedef enum logic [2:0] {INIT, READY, ACT, GAP, XFER, ACK} state_t;

    state_t                          state;
    sdram_pkg::cmd_t                 cmd_q;
    logic [sdram_pkg::BURST_LOG2-1:0] cnt;
    logic                            ack_q;
    logic                            we_q;
    sdram_pkg::addr_t                a_q;
    sdram_pkg::bank_t                ba_q;
    sdram_pkg::word_t                dq_q;
    sdram_pkg::burst_t               wbuf;
    sdram_pkg::burst_t               rbuf;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state <= INIT;
            cmd_q <= sdram_pkg::NOP;
            cnt   <= '0;
            ack_q <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    if (cmd_q == sdram_pkg::LOAD_MODE) begin
                        cmd_q <= sdram_pkg::NOP; // one idle cycle after the mode load
                        state <= READY;
                    end else begin
                        cmd_q <= sdram_pkg::LOAD_MODE;
                    end
                end
                READY: begin
                    if (req_i) begin
                        cmd_q <= sdram_pkg::ACTIVE;
                        state <= ACT;
                    end
                end
                ACT: begin
                    cmd_q <= sdram_pkg::NOP;
                    state <= GAP;
                end
                GAP: begin
                    cmd_q <= we_q ? sdram_pkg::WRITE : sdram_pkg::READ;
                    cnt   <= '0;
                    state <= XFER;
                end
                XFER: begin
                    cmd_q <= sdram_pkg::NOP;
                    if (we_q || sd_dq_oe_i) begin // one word per step
                        if (int'(cnt) == sdram_pkg::BURST_LEN - 1) begin
                            ack_q <= 1'b1;
                            state <= ACK;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                ACK: begin
                    if (!req_i) begin
                        ack_q <= 1'b0;
                        state <= READY;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            INIT: a_q <= sdram_pkg::MODE_WORD;
            READY: begin
                we_q <= we_i;
                ba_q <= addr_i[sdram_pkg::COL_W+sdram_pkg::ROW_W +: sdram_pkg::BANK_W];
                a_q  <= sdram_pkg::addr_t'(addr_i[sdram_pkg::COL_W +: sdram_pkg::ROW_W]);
            end
            GAP: begin
                a_q  <= sdram_pkg::addr_t'(addr_i[sdram_pkg::COL_W-1:0]);
                dq_q <= wdata_i[sdram_pkg::DATA_W-1:0];
                wbuf <= wdata_i >> sdram_pkg::DATA_W;
            end
            XFER: begin
                dq_q <= wbuf[sdram_pkg::DATA_W-1:0];
                wbuf <= wbuf >> sdram_pkg::DATA_W;
                if (!we_q && sd_dq_oe_i) begin
                    rbuf <= {sd_dq_i, rbuf[$bits(sdram_pkg::burst_t)-1:sdram_pkg::DATA_W]};
                end
            end
            default: dq_q <= dq_q;
        endcase
    end

    assign sd_cs_o                       = (cmd_q == sdram_pkg::NOP); // deselect when idle
    assign {sd_ras_o, sd_cas_o, sd_we_o} = cmd_q;
    assign sd_a_o                        = a_q;
    assign sd_ba_o                       = ba_q;
    assign sd_dq_o                       = dq_q;
    assign ack_o                         = ack_q;
    assign rdata_o                       = rbuf;

endmodule

`default_nettype wire

//--- sdram_model/sdram_model.sv
// behavioral SDRAM model
// row table and burst sequencer side by side feeding the storage array
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                    clk,
    input  wire                    cke,
    input  wire                    cs_i,
    input  wire                    ras_i,
    input  wire                    cas_i,
    input  wire                    we_i,
    input  wire sdram_pkg::addr_t  a_i,
    input  wire sdram_pkg::bank_t  ba_i,
    input  wire sdram_pkg::word_t  dq_i,
    output wire sdram_pkg::word_t  dq_o,
    output wire                    dq_oe_o
);

    sdram_pkg::cmd_t  cmd;
    sdram_pkg::bank_t bank;
    sdram_pkg::col_t  col;
    sdram_pkg::row_t  row;
    logic             wr_en;
    logic             rd_oe;

    sdram_burst_seq sdram_burst_seq_i (
        .clk     (clk),
        .cke     (cke),
        .cs_i    (cs_i),
        .ras_i   (ras_i),
        .cas_i   (cas_i),
        .we_i    (we_i),
        .ba_i    (ba_i),
        .a_i     (a_i),
        .cmd_o   (cmd),
        .bank_o  (bank),
        .col_o   (col),
        .wr_en_o (wr_en),
        .rd_oe_o (rd_oe)
    );

    sdram_row_table sdram_row_table_i (
        .clk       (clk),
        .cke       (cke),
        .cmd_i     (cmd),
        .ba_i      (ba_i),
        .a_i       (a_i[sdram_pkg::ROW_W-1:0]),
        .rd_bank_i (bank),
        .row_o     (row)
    );

    sdram_array sdram_array_i (
        .clk     (clk),
        .bank_i  (bank),
        .row_i   (row),
        .col_i   (col),
        .wr_en_i (wr_en),
        .wdata_i (dq_i),
        .rd_oe_i (rd_oe),
        .rdata_o (dq_o),
        .oe_o    (dq_oe_o)
    );

endmodule

`default_nettype wire

//--- sdram_model/sdram_array.sv
// word storage addressed by {bank, row, col}
// registered read port with its output enable
`timescale 1ns/1ps
`default_nettype none

module sdram_array (
    input  wire                    clk,
    input  wire sdram_pkg::bank_t  bank_i,
    input  wire sdram_pkg::row_t   row_i,
    input  wire sdram_pkg::col_t   col_i,
    input  wire                    wr_en_i,
    input  wire sdram_pkg::word_t  wdata_i,
    input  wire                    rd_oe_i,
    output sdram_pkg::word_t       rdata_o,
    output logic                   oe_o
);

    localparam int DEPTH_W = sdram_pkg::BANK_W + sdram_pkg::ROW_W + sdram_pkg::COL_W;

    sdram_pkg::word_t   mem [2**DEPTH_W];
    logic [DEPTH_W-1:0] addr;

    assign addr = {bank_i, row_i, col_i};

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[addr] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        oe_o <= rd_oe_i;
        if (rd_oe_i) begin
            rdata_o <= mem[addr]; // one cycle behind the sequencer
        end
    end

endmodule

`default_nettype wire

//--- sdram_model/sdram_burst_seq.sv
// command decode from cs/ras/cas/we and the load-mode register
// burst FSM stepping the column for write bursts and latency-delayed reads
`timescale 1ns/1ps
`default_nettype none

module sdram_burst_seq (
    input  wire                    clk,
    input  wire                    cke,
    input  wire                    cs_i,
    input  wire                    ras_i,
    input  wire                    cas_i,
    input  wire                    we_i,
    input  wire sdram_pkg::bank_t  ba_i,
    input  wire sdram_pkg::addr_t  a_i,
    output sdram_pkg::cmd_t        cmd_o,
    output sdram_pkg::bank_t       bank_o,
    output sdram_pkg::col_t        col_o,
    output logic                   wr_en_o,
    output logic                   rd_oe_o
);

    typedef enum logic [1:0] {IDLE, WRITE, LATENCY, DATA} state_t;

    state_t           state;
    sdram_pkg::cmd_t  cmd;
    logic [2:0]       cl_q;
    sdram_pkg::col_t  bl_q;
    sdram_pkg::col_t  cnt;
    sdram_pkg::col_t  col_q;
    sdram_pkg::bank_t bank_q;
    sdram_pkg::col_t  a_col;

    always_comb begin
        cmd = sdram_pkg::NOP; // deselect or unsupported
        if (!cs_i) begin
            case ({ras_i, cas_i, we_i})
                3'b000:  cmd = sdram_pkg::LOAD_MODE;
                3'b011:  cmd = sdram_pkg::ACTIVE;
                3'b100:  cmd = sdram_pkg::WRITE;
                3'b101:  cmd = sdram_pkg::READ;
                default: cmd = sdram_pkg::NOP;
            endcase
        end
    end

    assign a_col = a_i[sdram_pkg::COL_W-1:0];

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cl_q <= 3'(sdram_pkg::CAS_LAT);
            bl_q <= sdram_pkg::col_t'(sdram_pkg::BURST_LEN);
        end else if (cmd == sdram_pkg::LOAD_MODE) begin
            cl_q <= a_i[6:4];
            bl_q <= sdram_pkg::col_t'(1) << a_i[2:0];
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd == sdram_pkg::WRITE && bl_q > 1) begin
                        state <= WRITE;
                        cnt   <= sdram_pkg::col_t'(1); // word 0 already stored
                    end else if (cmd == sdram_pkg::READ) begin
                        if (cl_q > 3'd2) begin
                            state <= LATENCY;
                            cnt   <= sdram_pkg::col_t'(1);
                        end else begin
                            state <= DATA;
                            cnt   <= '0;
                        end
                    end
                end
                WRITE: begin
                    if (cnt == bl_q - 1'b1) state <= IDLE;
                    else cnt <= cnt + 1'b1;
                end
                LATENCY: begin
                    // array output register adds the last cycle
                    if (cnt == sdram_pkg::col_t'(cl_q - 3'd2)) begin
                        state <= DATA;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (cnt == bl_q - 1'b1) state <= IDLE;
                    else cnt <= cnt + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            bank_q <= ba_i;
            col_q  <= (cmd == sdram_pkg::WRITE) ? a_col + 1'b1 : a_col;
        end else if (state != LATENCY) begin
            col_q <= col_q + 1'b1; // wraps inside the row
        end
    end

    assign cmd_o   = cmd;
    assign bank_o  = (state == IDLE) ? ba_i : bank_q;
    assign col_o   = (state == IDLE) ? a_col : col_q;
    assign wr_en_o = (state == IDLE && cmd == sdram_pkg::WRITE) || state == WRITE;
    assign rd_oe_o = (state == DATA);

endmodule

`default_nettype wire

//--- sdram_model/sdram_row_table.sv
// active row per bank loaded by activate commands
// row lookup for the bank the sequencer addresses
`timescale 1ns/1ps
`default_nettype none

module sdram_row_table (
    input  wire                    clk,
    input  wire                    cke,
    input  wire sdram_pkg::cmd_t   cmd_i,
    input  wire sdram_pkg::bank_t  ba_i,
    input  wire sdram_pkg::row_t   a_i,
    input  wire sdram_pkg::bank_t  rd_bank_i,
    output logic                   [sdram_pkg::ROW_W-1:0] row_o
);

    sdram_pkg::row_t rows [2**sdram_pkg::BANK_W];

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            for (int i = 0; i < 2**sdram_pkg::BANK_W; i++) begin
                rows[i] <= '0;
            end
        end else if (cmd_i == sdram_pkg::ACTIVE) begin
            rows[ba_i] <= a_i; // open row in this bank
        end
    end

    assign row_o = rows[rd_bank_i];

endmodule

`default_nettype wire

//--- common/sdram_pkg.sv
// geometry, timing and mode-word constants for the SDRAM subsystem
// typedefs for bank/row/column/word, host bursts and decoded commands
`default_nettype none

package sdram_pkg;

    localparam int BANK_W     = 2;
    localparam int ROW_W      = 4;
    localparam int COL_W      = 5;
    localparam int DATA_W     = 16;
    localparam int ADDR_W     = 13; // a bus as on the device
    localparam int BURST_LEN  = 4;
    localparam int BURST_LOG2 = $clog2(BURST_LEN);
    localparam int CAS_LAT    = 2;

    typedef logic [BANK_W-1:0]                 bank_t;
    typedef logic [ROW_W-1:0]                  row_t;
    typedef logic [COL_W-1:0]                  col_t;
    typedef logic [DATA_W-1:0]                 word_t;
    typedef logic [ADDR_W-1:0]                 addr_t;
    typedef logic [BURST_LEN*DATA_W-1:0]       burst_t;     // word 0 in low bits
    typedef logic [BANK_W+ROW_W+COL_W-1:0]     host_addr_t; // {bank, row, col}

    // cas latency in 6:4, log2 burst length in 2:0
    localparam addr_t MODE_WORD = addr_t'((CAS_LAT << 4) | BURST_LOG2);

    // values are the {ras, cas, we} levels with cs low
    typedef enum logic [2:0] {
        LOAD_MODE = 3'b000,
        ACTIVE    = 3'b011,
        WRITE     = 3'b100,
        READ      = 3'b101,
        NOP       = 3'b111
    } cmd_t;

endpackage

`default_nettype wire
